// File: list.f
stk_pkg.sv
stk_ram.sv
stk_regs.sv
stk_seq.sv
stk_core.sv
tb_clk.sv
stk_tb.sv

// File: Bender.yml
package:
  name: stk_core

sources:
  - stk_pkg.sv
  - stk_ram.sv
  - stk_regs.sv
  - stk_seq.sv
  - stk_core.sv
  - target: test
    files:
      - tb_clk.sv
      - stk_tb.sv

// File: stk_tb.sv
/* testbench for the stack transfer block
   reference model of registers and stack, checks transfers, pushes and pulls */
`timescale 1ns/1ps

module stk_tb;
    import stk_pkg::*;

    localparam int RAM_AW = 10;

    logic        clk;
    logic        rst;
    stk_cmd_t    cmd;
    logic        cmd_valid;
    logic [7:0]  cc_in;
    logic [15:0] pc_in;
    logic        busy;
    logic        done;
    reg_code_t   tfr_sel;
    logic [15:0] tfr_data;
    logic [1:0]  idx_sel;
    logic [15:0] idx_data;
    logic [15:0] acc;
    logic        pul_cc;
    logic        pul_pc;
    logic [7:0]  pul_data;
    logic        pul_hilon;

    // model registers and stack bytes
    logic [7:0]  m_a;
    logic [7:0]  m_b;
    logic [7:0]  m_dp;
    logic [15:0] m_x;
    logic [15:0] m_y;
    logic [15:0] m_u;
    logic [15:0] m_s;
    logic [7:0]  stk_m [2**RAM_AW];
    // expected CC/PC pull bytes as {is_pc, high, byte}
    logic [9:0]  pul_q [$];
    logic [9:0]  pul_exp;
    logic [9:0]  pul_act;
    integer      seed;
    int          n_fail;
    int          n_other;

    tb_clk u_clk (.clk(clk), .rst(rst));

    stk_core #(.RAM_AW(RAM_AW)) dut (
        .clk(clk), .rst(rst), .cmd(cmd), .cmd_valid(cmd_valid), .cc(cc_in), .pc(pc_in),
        .busy(busy), .done(done), .tfr_sel(tfr_sel), .tfr_data(tfr_data),
        .idx_sel(idx_sel), .idx_data(idx_data), .acc(acc), .pul_cc(pul_cc),
        .pul_pc(pul_pc), .pul_data(pul_data), .pul_hilon(pul_hilon)
    );

    // expected transfer source, D is A:B
    function automatic logic [15:0] tfr_exp(input reg_code_t code);
        case (code)
            4'd0:    return {m_a, m_b};
            4'd1:    return m_x;
            4'd2:    return m_y;
            4'd3:    return m_u;
            4'd4:    return m_s;
            4'd5:    return pc_in;
            4'd8:    return {8'hff, m_a};
            4'd9:    return {8'hff, m_b};
            4'd10:   return {8'hff, cc_in};
            4'd11:   return {8'hff, m_dp};
            default: return 16'd0;
        endcase
    endfunction

    // register value behind a mask bit
    function automatic logic [15:0] reg_word(input int i, input logic use_u);
        case (i)
            MASK_CC:    return {8'h00, cc_in};
            MASK_A:     return {8'h00, m_a};
            MASK_B:     return {8'h00, m_b};
            MASK_DP:    return {8'h00, m_dp};
            MASK_X:     return m_x;
            MASK_Y:     return m_y;
            MASK_OTHER: return use_u ? m_s : m_u;
            default:    return pc_in;
        endcase
    endfunction

    // frame bytes from lowest address up, returns the byte count
    function automatic int build_frame(input logic [7:0] mask, input logic use_u,
                                       output logic [95:0] fb);
        logic [15:0] w;
        int          k;
        k = 0;
        fb = '0;
        for (int i = 0; i < 8; i++) begin
            if (mask[i]) begin
                w = reg_word(i, use_u);
                if (i >= MASK_X) begin
                    fb[8*k +: 8] = w[15:8];
                    k++;
                end
                fb[8*k +: 8] = w[7:0];
                k++;
            end
        end
        return k;
    endfunction

    function automatic logic [7:0] mem_rd(input logic [15:0] addr);
        return stk_m[addr[RAM_AW-1:0]];
    endfunction

    task automatic model_load(input reg_code_t code, input logic [15:0] value);
        case (code)
            4'd1:    m_x = value;
            4'd2:    m_y = value;
            4'd3:    m_u = value;
            4'd4:    m_s = value;
            4'd8:    m_a = value[7:0];
            4'd9:    m_b = value[7:0];
            4'd11:   m_dp = value[7:0];
            default: m_x = m_x;
        endcase
    endtask

    task automatic model_push(input logic [7:0] mask, input logic use_u);
        logic [95:0] fb;
        logic [15:0] base;
        logic [15:0] ad;
        int          n;
        n = build_frame(mask, use_u, fb);
        base = (use_u ? m_u : m_s) - 16'(n);
        for (int k = 0; k < n; k++) begin
            ad = base + 16'(k);
            stk_m[ad[RAM_AW-1:0]] = fb[8*k +: 8];
        end
        if (use_u) m_u = base;
        else m_s = base;
    endtask

    task automatic model_pull(input logic [7:0] mask, input logic use_u);
        logic [15:0] ptr;
        logic [15:0] w;
        int          k;
        ptr = use_u ? m_u : m_s;
        k = 0;
        for (int i = 0; i < 8; i++) begin
            if (mask[i]) begin
                // high byte sits at the lower address
                if (i >= MASK_X) begin
                    w = {mem_rd(ptr + 16'(k)), mem_rd(ptr + 16'(k + 1))};
                    k = k + 2;
                end else begin
                    w = {8'h00, mem_rd(ptr + 16'(k))};
                    k = k + 1;
                end
                case (i)
                    MASK_CC: pul_q.push_back({1'b0, 1'b1, w[7:0]});
                    MASK_A:  m_a = w[7:0];
                    MASK_B:  m_b = w[7:0];
                    MASK_DP: m_dp = w[7:0];
                    MASK_X:  m_x = w;
                    MASK_Y:  m_y = w;
                    MASK_OTHER: begin
                        if (use_u) m_s = w;
                        else m_u = w;
                    end
                    default: begin
                        pul_q.push_back({1'b1, 1'b1, w[15:8]});
                        pul_q.push_back({1'b1, 1'b0, w[7:0]});
                    end
                endcase
            end
        end
        if (use_u) m_u = ptr + 16'(k);
        else m_s = ptr + 16'(k);
    endtask

    task automatic finish_run();
        $display("errors: %0d value mismatches, %0d other failures", n_fail, n_other);
        if (n_fail == 0 && n_other == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp) begin
            n_fail++;
            $display("FAIL t=%0t %s exp %h got %h", $time, name, exp, act);
        end
    endtask

    // sweep every transfer code and index select
    task automatic check_regs();
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            tfr_sel <= 4'(i);
            @(negedge clk);
            check_val($sformatf("tfr_data[%0d]", i), tfr_exp(4'(i)), tfr_data);
        end
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            idx_sel <= 2'(i);
            @(negedge clk);
            check_val($sformatf("idx_data[%0d]", i), tfr_exp(4'(i + 1)), idx_data);
        end
        check_val("acc", {m_b, m_a}, acc);
    endtask

    // model first, then one strobe and a bounded wait for done
    task automatic do_cmd(input cmd_kind_t kind, input logic [7:0] mask, input logic use_u,
                          input reg_code_t code, input logic [15:0] value);
        stk_cmd_t    c;
        logic [95:0] fb;
        int          n;
        int          lat;
        int          bcyc;
        int          want;
        logic        got;
        c.kind = kind;
        c.mask = mask;
        c.use_u = use_u;
        c.code = code;
        c.value = value;
        n = build_frame(mask, use_u, fb);
        // busy spans N+1 for push, two cycles per byte plus one for pull
        want = (kind == CMD_PULL) ? 2 * n + 1 : n + 1;
        if (kind == CMD_LOAD) want = 0;
        if (kind == CMD_LOAD) model_load(code, value);
        else if (kind == CMD_PUSH) model_push(mask, use_u);
        else model_pull(mask, use_u);
        @(posedge clk);
        cmd <= c;
        cmd_valid <= 1'b1;
        @(posedge clk);
        cmd_valid <= 1'b0;
        lat = 0;
        bcyc = 0;
        got = 1'b0;
        while (!got && lat < 200) begin
            @(negedge clk);
            lat++;
            if (busy) bcyc++;
            if (done) got = 1'b1;
        end
        if (!got) begin
            n_other++;
            $display("timeout: no done within 200 cycles after a command");
            finish_run();
        end else begin
            if (bcyc != want) begin
                n_fail++;
                $display("FAIL t=%0t busy_cycles exp %0d got %0d", $time, want, bcyc);
            end
            if (kind == CMD_LOAD && lat != 1) begin
                n_fail++;
                $display("FAIL t=%0t done_latency exp 1 got %0d", $time, lat);
            end
            if (pul_q.size() != 0) begin
                n_other++;
                $display("pull ended with %0d CC/PC bytes never strobed", pul_q.size());
                pul_q.delete();
            end
        end
    endtask

    // new random values for the registers behind a mask
    task automatic reload_mask(input logic [7:0] mask, input logic use_u);
        reg_code_t codes [8];
        codes = '{REG_CC, REG_A, REG_B, REG_DP, REG_X, REG_Y, REG_U, REG_PC};
        if (use_u) codes[MASK_OTHER] = REG_S;
        for (int i = 0; i < 8; i++) begin
            if (mask[i]) do_cmd(CMD_LOAD, 8'd0, use_u, codes[i], 16'($random(seed)));
        end
    endtask

    task automatic new_cc_pc();
        @(posedge clk);
        cc_in <= 8'($random(seed));
        pc_in <= 16'($random(seed));
        @(negedge clk);
    endtask

    // CC/PC pull strobes against the expected byte order
    always @(negedge clk) begin
        if (!rst && (pul_cc || pul_pc)) begin
            pul_act = {pul_pc, pul_pc ? pul_hilon : 1'b1, pul_data};
            if (pul_q.size() == 0) begin
                n_other++;
                $display("unexpected CC/PC pull strobe at t=%0t", $time);
            end else begin
                pul_exp = pul_q.pop_front();
                if (pul_act !== pul_exp) begin
                    n_fail++;
                    $display("FAIL t=%0t pul_data exp %h got %h", $time, pul_exp, pul_act);
                end
            end
        end
    end

    initial begin
        logic [7:0]  mask;
        logic [31:0] r;
        int          t;
        seed = 31;
        n_fail = 0;
        n_other = 0;
        cmd = '0;
        cmd_valid = 1'b0;
        tfr_sel = 4'd0;
        idx_sel = 2'd0;
        cc_in = 8'($random(seed));
        pc_in = 16'($random(seed));
        m_a = 8'd0;
        m_b = 8'd0;
        m_dp = 8'd0;
        m_x = 16'd0;
        m_y = 16'd0;
        m_u = 16'd0;
        m_s = 16'd0;
        t = 0;
        while (rst && t < 50) begin
            @(negedge clk);
            t++;
        end
        if (rst) begin
            n_other++;
            $display("reset was never released");
            finish_run();
        end else begin
            // reset values, then loads and ignored codes
            check_regs();
            reload_mask(8'hff, 1'b0);
            do_cmd(CMD_LOAD, 8'd0, 1'b0, REG_S, 16'($random(seed)));
            check_regs();
            do_cmd(CMD_LOAD, 8'd0, 1'b0, REG_D, 16'($random(seed)));
            do_cmd(CMD_LOAD, 8'd0, 1'b0, REG_PC, 16'($random(seed)));
            do_cmd(CMD_LOAD, 8'd0, 1'b0, REG_CC, 16'($random(seed)));
            check_regs();
            // S stack round trip with CC and PC present
            mask = 8'($random(seed));
            mask[MASK_CC] = 1'b1;
            mask[MASK_PC] = 1'b1;
            do_cmd(CMD_PUSH, mask, 1'b0, REG_D, 16'd0);
            check_regs();
            reload_mask(mask, 1'b0);
            new_cc_pc();
            do_cmd(CMD_PULL, mask, 1'b0, REG_D, 16'd0);
            check_regs();
            // U stack carries S as the other pointer
            mask = 8'($random(seed)) | 8'h40;
            do_cmd(CMD_PUSH, mask, 1'b1, REG_D, 16'd0);
            check_regs();
            reload_mask(mask, 1'b1);
            do_cmd(CMD_PULL, mask, 1'b1, REG_D, 16'd0);
            check_regs();
            // empty mask finishes right away
            do_cmd(CMD_PUSH, 8'd0, 1'b0, REG_D, 16'd0);
            do_cmd(CMD_PULL, 8'd0, 1'b1, REG_D, 16'd0);
            // random sequences, pull mask a subset so only written bytes come back
            repeat (40) begin
                new_cc_pc();
                r = $random(seed);
                do_cmd(CMD_LOAD, 8'd0, r[4], r[3:0], 16'($random(seed)));
                mask = 8'($random(seed));
                do_cmd(CMD_PUSH, mask, r[4], REG_D, 16'd0);
                new_cc_pc();
                mask = mask & 8'($random(seed));
                do_cmd(CMD_PULL, mask, r[4], REG_D, 16'd0);
                check_regs();
            end
            finish_run();
        end
    end

endmodule

// File: tb_clk.sv
/* testbench clock and reset
   10 ns clock, reset held high for the first 10 cycles */
`timescale 1ns/1ps

module tb_clk (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // release on a rising edge
    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: stk_core.sv
/* register file and stack transfer block
   sequencer, registers and stack memory */
`timescale 1ns/1ps

module stk_core #(
    parameter int RAM_AW = 10
) (
    input  logic               clk,
    input  logic               rst,
    input  stk_pkg::stk_cmd_t  cmd,
    input  logic               cmd_valid,
    input  logic [7:0]         cc,
    input  logic [15:0]        pc,
    output logic               busy,
    output logic               done,
    input  stk_pkg::reg_code_t tfr_sel,
    output logic [15:0]        tfr_data,
    input  logic [1:0]         idx_sel,
    output logic [15:0]        idx_data,
    output logic [15:0]        acc,
    output logic               pul_cc,
    output logic               pul_pc,
    output logic [7:0]         pul_data,
    output logic               pul_hilon
);
    import stk_pkg::*;

    reg_upd_t          upd;
    stk_ctl_t          ctl;
    logic [15:0]       alu;
    logic [7:0]        psh_byte;
    logic [7:0]        psh_bit;
    logic [15:0]       psh_addr;
    logic [RAM_AW-1:0] mem_addr;
    logic              mem_we;
    logic [7:0]        mem_wdata;
    logic [7:0]        rd_data;

    // CC/PC bytes leave on the bus for the owner
    assign pul_data  = alu[7:0];
    assign pul_hilon = ctl.hilon;

    stk_seq #(.RAM_AW(RAM_AW)) u_seq (
        .clk(clk), .rst(rst), .cmd(cmd), .cmd_valid(cmd_valid),
        .psh_byte(psh_byte), .psh_bit(psh_bit), .psh_addr(psh_addr), .rd_data(rd_data),
        .busy(busy), .done(done), .upd(upd), .ctl(ctl), .alu(alu),
        .mem_addr(mem_addr), .mem_we(mem_we), .mem_wdata(mem_wdata)
    );

    stk_regs u_regs (
        .clk(clk), .rst(rst), .ctl(ctl), .upd(upd), .alu(alu), .cc(cc), .pc(pc),
        .tfr_sel(tfr_sel), .idx_sel(idx_sel), .tfr_data(tfr_data), .idx_data(idx_data),
        .acc(acc), .psh_byte(psh_byte), .psh_bit(psh_bit), .psh_addr(psh_addr),
        .pul_cc(pul_cc), .pul_pc(pul_pc)
    );

    stk_ram #(.RAM_AW(RAM_AW)) u_ram (
        .clk(clk), .addr(mem_addr), .we(mem_we), .wdata(mem_wdata), .rdata(rd_data)
    );

endmodule

// File: stk_seq.sv
/* push/pull sequencer
   decodes commands, walks the register mask one byte per step */
`timescale 1ns/1ps

module stk_seq #(
    parameter int RAM_AW = 10
) (
    input  logic              clk,
    input  logic              rst,
    input  stk_pkg::stk_cmd_t cmd,
    input  logic              cmd_valid,
    input  logic [7:0]        psh_byte,
    input  logic [7:0]        psh_bit,
    input  logic [15:0]       psh_addr,
    input  logic [7:0]        rd_data,
    output logic              busy,
    output logic              done,
    output stk_pkg::reg_upd_t upd,
    output stk_pkg::stk_ctl_t ctl,
    output logic [15:0]       alu,
    output logic [RAM_AW-1:0] mem_addr,
    output logic              mem_we,
    output logic [7:0]        mem_wdata
);
    import stk_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_PUSH,
        S_PULL_RD,
        S_PULL_TK
    } state_t;

    state_t            state;
    logic [7:0]        sel_q;
    logic              hilon_q;
    logic              ussel_q;
    logic [RAM_AW-1:0] base_q;
    logic [3:0]        idx_q;
    logic [3:0]        n_bytes;
    logic              accept;
    logic              step;
    logic              step_hi;
    logic [7:0]        sel_left;
    logic              last_byte;

    assign accept = cmd_valid && !busy;

    // byte count, two per 16-bit register
    always_comb begin
        n_bytes = 4'd0;
        for (int i = 0; i < 8; i++) begin
            if (cmd.mask[i]) n_bytes = n_bytes + ((i >= MASK_X) ? 4'd2 : 4'd1);
        end
    end

    // a byte moves in push and in the take half of pull
    assign step      = (state == S_PUSH) || (state == S_PULL_TK);
    assign step_hi   = hilon_q && (psh_bit[7:MASK_X] != 4'd0);
    assign sel_left  = sel_q & ~psh_bit;
    assign last_byte = !step_hi && (sel_left == 8'd0);

    assign ctl.sel    = sel_q;
    assign ctl.hilon  = hilon_q;
    assign ctl.ussel  = (state == S_IDLE) ? cmd.use_u : ussel_q;
    assign ctl.pul_en = (state == S_PULL_TK);
    assign ctl.dec_us = (state == S_PUSH);

    // memory bytes only pass through low
    assign alu       = ctl.pul_en ? {8'h00, rd_data} : cmd.value;
    assign mem_we    = (state == S_PUSH);
    assign mem_wdata = psh_byte;
    assign mem_addr  = mem_we ? base_q + RAM_AW'(idx_q) : psh_addr[RAM_AW-1:0];

    // load strobes, codes D, PC and CC fall through
    always_comb begin
        upd = '0;
        if (accept && cmd.kind == CMD_LOAD) begin
            case (cmd.code)
                REG_A:   upd.a  = 1'b1;
                REG_B:   upd.b  = 1'b1;
                REG_DP:  upd.dp = 1'b1;
                REG_X:   upd.x  = 1'b1;
                REG_Y:   upd.y  = 1'b1;
                REG_U:   upd.u  = 1'b1;
                REG_S:   upd.s  = 1'b1;
                default: upd    = '0;
            endcase
        end
    end

    // push base, lowest address of the frame
    always_ff @(posedge clk) begin
        if (state == S_IDLE) base_q <= psh_addr[RAM_AW-1:0] - RAM_AW'(n_bytes);
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state   <= S_IDLE;
            sel_q   <= 8'd0;
            hilon_q <= 1'b1;
            ussel_q <= 1'b0;
            idx_q   <= 4'd0;
            busy    <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (done) busy <= 1'b0;
            if (state == S_IDLE && accept) begin
                sel_q   <= cmd.mask;
                hilon_q <= 1'b1;
                ussel_q <= cmd.use_u;
                idx_q   <= 4'd0;
                busy    <= (cmd.kind == CMD_PUSH) || (cmd.kind == CMD_PULL);
                // loads and empty masks finish at once
                if (cmd.kind == CMD_PUSH && cmd.mask != 8'd0) state <= S_PUSH;
                else if (cmd.kind == CMD_PULL && cmd.mask != 8'd0) state <= S_PULL_RD;
                else done <= 1'b1;
            end else if (state == S_PULL_RD) begin
                state <= S_PULL_TK;
            end else if (step) begin
                idx_q <= idx_q + 4'd1;
                if (step_hi) begin
                    hilon_q <= 1'b0;
                end else begin
                    sel_q   <= sel_left;
                    hilon_q <= 1'b1;
                end
                if (last_byte) begin
                    state <= S_IDLE;
                    done  <= 1'b1;
                end else if (state == S_PULL_TK) begin
                    state <= S_PULL_RD;
                end
            end
        end
    end

    // a moving byte always has a register left in the mask
    a_step_has_reg: assert property (@(posedge clk) disable iff (rst)
        (ctl.pul_en || ctl.dec_us) |-> sel_q != 8'd0);
    // writes only while the push is still running
    a_we_in_push: assert property (@(posedge clk) disable iff (rst)
        mem_we |-> busy && !done);

endmodule

// File: stk_regs.sv
/* register file with A, B, DP, X, Y, U and S
   transfer and index muxes, push byte select, pull strobes, U/S update */
`timescale 1ns/1ps

module stk_regs (
    input  logic                clk,
    input  logic                rst,
    input  stk_pkg::stk_ctl_t   ctl,
    input  stk_pkg::reg_upd_t   upd,
    input  logic [15:0]         alu,
    input  logic [7:0]          cc,
    input  logic [15:0]         pc,
    input  stk_pkg::reg_code_t  tfr_sel,
    input  logic [1:0]          idx_sel,
    output logic [15:0]         tfr_data,
    output logic [15:0]         idx_data,
    output logic [15:0]         acc,
    output logic [7:0]          psh_byte,
    output logic [7:0]          psh_bit,
    output logic [15:0]         psh_addr,
    output logic                pul_cc,
    output logic                pul_pc
);
    import stk_pkg::*;

    logic [7:0]  a;
    logic [7:0]  b;
    logic [7:0]  dp;
    logic [15:0] x;
    logic [15:0] y;
    logic [15:0] u;
    logic [15:0] s;
    logic [15:0] nx_u;
    logic [15:0] nx_s;
    logic [15:0] psh_other;
    logic        pul_a;
    logic        pul_b;
    logic        pul_dp;
    logic        pul_x;
    logic        pul_y;
    logic        pul_other;
    logic        pul_any;

    assign acc       = {b, a};
    // active stack and the one that travels as OTHER
    assign psh_addr  = ctl.ussel ? u : s;
    assign psh_other = ctl.ussel ? s : u;

    // exg/tfr source, 8-bit regs read FF on top
    always_comb begin
        case (tfr_sel)
            REG_D:   tfr_data = {a, b};
            REG_X:   tfr_data = x;
            REG_Y:   tfr_data = y;
            REG_U:   tfr_data = u;
            REG_S:   tfr_data = s;
            REG_PC:  tfr_data = pc;
            REG_A:   tfr_data = {8'hff, a};
            REG_B:   tfr_data = {8'hff, b};
            REG_CC:  tfr_data = {8'hff, cc};
            REG_DP:  tfr_data = {8'hff, dp};
            default: tfr_data = 16'd0;
        endcase
    end

    // indexed base
    always_comb begin
        case (idx_sel)
            2'd0:    idx_data = x;
            2'd1:    idx_data = y;
            2'd2:    idx_data = u;
            default: idx_data = s;
        endcase
    end

    // lowest remaining mask bit wins
    always_comb begin
        psh_bit  = 8'd0;
        psh_byte = 8'd0;
        if (ctl.sel[MASK_CC]) begin
            psh_bit[MASK_CC] = 1'b1;
            psh_byte         = cc;
        end else if (ctl.sel[MASK_A]) begin
            psh_bit[MASK_A] = 1'b1;
            psh_byte        = a;
        end else if (ctl.sel[MASK_B]) begin
            psh_bit[MASK_B] = 1'b1;
            psh_byte        = b;
        end else if (ctl.sel[MASK_DP]) begin
            psh_bit[MASK_DP] = 1'b1;
            psh_byte         = dp;
        end else if (ctl.sel[MASK_X]) begin
            psh_bit[MASK_X] = 1'b1;
            psh_byte        = ctl.hilon ? x[15:8] : x[7:0];
        end else if (ctl.sel[MASK_Y]) begin
            psh_bit[MASK_Y] = 1'b1;
            psh_byte        = ctl.hilon ? y[15:8] : y[7:0];
        end else if (ctl.sel[MASK_OTHER]) begin
            psh_bit[MASK_OTHER] = 1'b1;
            psh_byte            = ctl.hilon ? psh_other[15:8] : psh_other[7:0];
        end else if (ctl.sel[MASK_PC]) begin
            psh_bit[MASK_PC] = 1'b1;
            psh_byte         = ctl.hilon ? pc[15:8] : pc[7:0];
        end
    end

    // pull strobes follow the same priority
    assign pul_cc    = ctl.pul_en & psh_bit[MASK_CC];
    assign pul_a     = ctl.pul_en & psh_bit[MASK_A];
    assign pul_b     = ctl.pul_en & psh_bit[MASK_B];
    assign pul_dp    = ctl.pul_en & psh_bit[MASK_DP];
    assign pul_x     = ctl.pul_en & psh_bit[MASK_X];
    assign pul_y     = ctl.pul_en & psh_bit[MASK_Y];
    assign pul_other = ctl.pul_en & psh_bit[MASK_OTHER];
    assign pul_pc    = ctl.pul_en & psh_bit[MASK_PC];
    assign pul_any   = pul_cc | pul_a | pul_b | pul_dp | pul_x | pul_y | pul_other | pul_pc;

    // U/S next value, four sources
    always_comb begin
        nx_u = u;
        nx_s = s;
        if (upd.u) nx_u = alu;
        if (upd.s) nx_s = alu;
        // one byte pushed
        if (ctl.dec_us) begin
            if (ctl.ussel) nx_u = u - 16'd1;
            else           nx_s = s - 16'd1;
        end
        // one byte pulled
        if (pul_any) begin
            if (ctl.ussel) nx_u = u + 16'd1;
            else           nx_s = s + 16'd1;
        end
        // pulled byte lands in the other pointer
        if (pul_other) begin
            if (ctl.ussel && ctl.hilon)  nx_s[15:8] = alu[7:0];
            if (ctl.ussel && !ctl.hilon) nx_s[7:0]  = alu[7:0];
            if (!ctl.ussel && ctl.hilon)  nx_u[15:8] = alu[7:0];
            if (!ctl.ussel && !ctl.hilon) nx_u[7:0]  = alu[7:0];
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            a  <= 8'd0;
            b  <= 8'd0;
            dp <= 8'd0;
            x  <= 16'd0;
            y  <= 16'd0;
            u  <= 16'd0;
            s  <= 16'd0;
        end else begin
            u <= nx_u;
            s <= nx_s;
            if (upd.a || pul_a)   a  <= alu[7:0];
            if (upd.b || pul_b)   b  <= alu[7:0];
            if (upd.dp || pul_dp) dp <= alu[7:0];
            if (upd.x) x <= alu;
            if (upd.y) y <= alu;
            // memory bytes, high one first
            if (pul_x && ctl.hilon)  x[15:8] <= alu[7:0];
            if (pul_x && !ctl.hilon) x[7:0]  <= alu[7:0];
            if (pul_y && ctl.hilon)  y[15:8] <= alu[7:0];
            if (pul_y && !ctl.hilon) y[7:0]  <= alu[7:0];
        end
    end

    // a taken byte lands in exactly one register
    a_pul_onehot: assert property (@(posedge clk) disable iff (rst)
        ctl.pul_en |-> $onehot({pul_cc, pul_a, pul_b, pul_dp, pul_x, pul_y, pul_other, pul_pc}));

endmodule

// File: stk_ram.sv
/* byte-wide stack memory
   single port, registered read */
`timescale 1ns/1ps

module stk_ram #(
    parameter int RAM_AW = 10
) (
    input  logic              clk,
    input  logic [RAM_AW-1:0] addr,
    input  logic              we,
    input  logic [7:0]        wdata,
    output logic [7:0]        rdata
);

    logic [7:0] mem [2**RAM_AW];

    // read data one cycle after the address
    always_ff @(posedge clk) begin
        if (we) mem[addr] <= wdata;
        rdata <= mem[addr];
    end

    // pointer arithmetic upstream must not leak X into a write
    a_addr_known: assert property (@(posedge clk)
        we |-> !$isunknown(addr));

endmodule

// File: stk_pkg.sv
/* stack transfer package
   command kinds, register codes, mask positions and the strobe/control
   structs shared by the sequencer and the register file */
package stk_pkg;

    // command kinds carried on the command port
    typedef enum logic [1:0] {
        CMD_LOAD,
        CMD_PUSH,
        CMD_PULL
    } cmd_kind_t;

    // transfer postbyte numbering
    typedef logic [3:0] reg_code_t;

    localparam reg_code_t REG_D  = 4'd0;
    localparam reg_code_t REG_X  = 4'd1;
    localparam reg_code_t REG_Y  = 4'd2;
    localparam reg_code_t REG_U  = 4'd3;
    localparam reg_code_t REG_S  = 4'd4;
    localparam reg_code_t REG_PC = 4'd5;
    localparam reg_code_t REG_A  = 4'd8;
    localparam reg_code_t REG_B  = 4'd9;
    localparam reg_code_t REG_CC = 4'd10;
    localparam reg_code_t REG_DP = 4'd11;

    // push/pull mask bits, lowest goes first
    localparam int MASK_CC    = 0;
    localparam int MASK_A     = 1;
    localparam int MASK_B     = 2;
    localparam int MASK_DP    = 3;
    localparam int MASK_X     = 4;
    localparam int MASK_Y     = 5;
    localparam int MASK_OTHER = 6;
    localparam int MASK_PC    = 7;

    typedef struct packed {
        cmd_kind_t  kind;
        logic [7:0] mask;
        logic       use_u;
        reg_code_t  code;
        logic [15:0] value;
    } stk_cmd_t;

    // one load strobe per owned register
    typedef struct packed {
        logic a;
        logic b;
        logic dp;
        logic x;
        logic y;
        logic u;
        logic s;
    } reg_upd_t;

    typedef struct packed {
        logic [7:0] sel;
        logic       hilon;
        logic       ussel;
        logic       pul_en;
        logic       dec_us;
    } stk_ctl_t;

endpackage
